// File: hw/brat_pkg.sv
`default_nettype none

package brat_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int BRAT_DEPTH    = 8;
    localparam int EXEC_LANES    = 3;
    localparam int RELEASE_WIDTH = 3;

    // ====================
    // Vector types
    // ====================
    typedef logic [31:0] pc_t;

    // Same width as the core's physical/ROB id
    typedef logic [5:0]  rob_id_t;

    typedef logic [2:0]  brat_ptr_t;

    // Occupancy from 0 up to BRAT_DEPTH
    typedef logic [3:0]  brat_cnt_t;

    // Return-stack top-of-stack checkpoint
    typedef logic [2:0]  ras_tos_t;

    // One bit per release slot
    typedef logic [2:0]  slot_mask_t;

endpackage

`default_nettype wire

// File: hw/brat_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

// One execute lane reporting a branch outcome
interface brat_exec_if;
    import brat_pkg::*;

    logic    valid;
    rob_id_t rob_id;
    logic    mispredicted;
    pc_t     correct_pc;
    logic    is_jalr;

    // Lane side driven from the top-level ports
    modport source (
        output valid,
        output rob_id,
        output mispredicted,
        output correct_pc,
        output is_jalr
    );

    // Table side
    modport tbl (
        input valid,
        input rob_id,
        input mispredicted,
        input correct_pc,
        input is_jalr
    );

endinterface

`default_nettype wire

// File: hw/brat_release_if.sv
`timescale 1ns/1ps
`default_nettype none

// In-order release window with the oldest branch in slot 0
interface brat_release_if;
    import brat_pkg::*;

    slot_mask_t valid;
    rob_id_t    rob_id           [RELEASE_WIDTH];
    slot_mask_t mispredicted;
    pc_t        correct_pc       [RELEASE_WIDTH];
    pc_t        pc_at_prediction [RELEASE_WIDTH];
    slot_mask_t is_jalr;
    ras_tos_t   ras_tos          [RELEASE_WIDTH];

    modport tbl (
        output valid,
        output rob_id,
        output mispredicted,
        output correct_pc,
        output pc_at_prediction,
        output is_jalr,
        output ras_tos
    );

    modport recovery (
        input valid,
        input rob_id,
        input mispredicted,
        input correct_pc,
        input pc_at_prediction,
        input is_jalr,
        input ras_tos
    );

endinterface

`default_nettype wire

// File: hw/brat_table.sv
`timescale 1ns/1ps
`default_nettype none

module brat_table (
    input  wire logic          clk,
    input  wire logic          rst_i,

    input  wire logic          alloc_valid_i,
    input  brat_pkg::rob_id_t  alloc_rob_id_i,
    input  brat_pkg::pc_t      alloc_pc_i,
    input  brat_pkg::ras_tos_t alloc_ras_tos_i,
    output logic               alloc_ready_o,

    brat_exec_if.tbl           exec [brat_pkg::EXEC_LANES],
    brat_release_if.tbl        rel
);
    import brat_pkg::*;

    // ====================
    // Entry state
    // ====================
    logic [BRAT_DEPTH-1:0] ent_valid;
    logic [BRAT_DEPTH-1:0] ent_resolved;
    logic [BRAT_DEPTH-1:0] ent_misp;
    logic [BRAT_DEPTH-1:0] ent_jalr;
    rob_id_t               ent_rob_id     [BRAT_DEPTH];
    pc_t                   ent_pc         [BRAT_DEPTH];
    pc_t                   ent_correct_pc [BRAT_DEPTH];
    ras_tos_t              ent_ras_tos    [BRAT_DEPTH];

    brat_ptr_t head;
    brat_ptr_t tail;
    brat_cnt_t count;

    logic alloc_fire;

    // Lane results copied out of the interface array
    logic    lane_valid   [EXEC_LANES];
    rob_id_t lane_rob_id  [EXEC_LANES];
    logic    lane_misp    [EXEC_LANES];
    pc_t     lane_pc      [EXEC_LANES];
    logic    lane_jalr    [EXEC_LANES];
    logic    lane_dup;

    // Per-entry resolution this cycle
    logic [BRAT_DEPTH-1:0] res_hit;
    logic [BRAT_DEPTH-1:0] res_misp;
    logic [BRAT_DEPTH-1:0] res_jalr;
    pc_t                   res_pc [BRAT_DEPTH];

    // Release window
    brat_ptr_t  slot_idx [RELEASE_WIDTH];
    slot_mask_t rel_valid;
    slot_mask_t rel_misp;
    slot_mask_t rel_jalr;
    brat_cnt_t  rel_cnt;
    logic       squash;

    assign alloc_ready_o = (count < brat_cnt_t'(BRAT_DEPTH));
    assign alloc_fire    = alloc_valid_i && alloc_ready_o;

    for (genvar l = 0; l < EXEC_LANES; l++) begin : g_lane
        assign lane_valid[l]  = exec[l].valid;
        assign lane_rob_id[l] = exec[l].rob_id;
        assign lane_misp[l]   = exec[l].mispredicted;
        assign lane_pc[l]     = exec[l].correct_pc;
        assign lane_jalr[l]   = exec[l].is_jalr;
    end

    // ====================
    // Resolution match
    // ====================
    // Only live, still unresolved entries can take a result
    always_comb begin
        for (int e = 0; e < BRAT_DEPTH; e++) begin
            res_hit[e]  = 1'b0;
            res_misp[e] = 1'b0;
            res_jalr[e] = 1'b0;
            res_pc[e]   = '0;
            for (int l = 0; l < EXEC_LANES; l++) begin
                if (lane_valid[l] && ent_valid[e] && !ent_resolved[e] &&
                    (lane_rob_id[l] == ent_rob_id[e])) begin
                    res_hit[e]  = 1'b1;
                    res_misp[e] = lane_misp[l];
                    res_jalr[e] = lane_jalr[l];
                    res_pc[e]   = lane_pc[l];
                end
            end
        end
    end

    always_comb begin
        lane_dup = 1'b0;
        for (int a = 0; a < EXEC_LANES; a++) begin
            for (int b = a + 1; b < EXEC_LANES; b++) begin
                if (lane_valid[a] && lane_valid[b] && (lane_rob_id[a] == lane_rob_id[b])) begin
                    lane_dup = 1'b1;
                end
            end
        end
    end

    // ====================
    // Release window
    // ====================
    // Walk from the head, stop at the first unresolved entry
    // or right after a mispredicted one
    always_comb begin
        logic stop;
        stop      = 1'b0;
        rel_valid = '0;
        rel_misp  = '0;
        rel_jalr  = '0;
        rel_cnt   = '0;
        for (int k = 0; k < RELEASE_WIDTH; k++) begin
            slot_idx[k] = head + brat_ptr_t'(k);
            rel_jalr[k] = ent_jalr[slot_idx[k]];
            if (!stop && ent_valid[slot_idx[k]] && ent_resolved[slot_idx[k]]) begin
                rel_valid[k] = 1'b1;
                rel_misp[k]  = ent_misp[slot_idx[k]];
                rel_cnt      = rel_cnt + 1'b1;
                if (ent_misp[slot_idx[k]]) begin
                    stop = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    assign squash = |rel_misp;

    always_comb begin
        rel.valid        = rel_valid;
        rel.mispredicted = rel_misp;
        rel.is_jalr      = rel_jalr;
        for (int k = 0; k < RELEASE_WIDTH; k++) begin
            rel.rob_id[k]           = ent_rob_id[slot_idx[k]];
            rel.correct_pc[k]       = ent_correct_pc[slot_idx[k]];
            rel.pc_at_prediction[k] = ent_pc[slot_idx[k]];
            rel.ras_tos[k]          = ent_ras_tos[slot_idx[k]];
        end
    end

    // ====================
    // Control state
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_valid    <= '0;
            ent_resolved <= '0;
        end else if (squash) begin
            // Everything younger is wrong-path, incoming allocation included
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_valid    <= '0;
            ent_resolved <= '0;
        end else begin
            ent_resolved <= ent_resolved | res_hit;
            for (int k = 0; k < RELEASE_WIDTH; k++) begin
                if (rel_valid[k]) begin
                    ent_valid[slot_idx[k]] <= 1'b0;
                end
            end
            if (alloc_fire) begin
                ent_valid[tail]    <= 1'b1;
                ent_resolved[tail] <= 1'b0;
                tail               <= tail + 1'b1;
            end
            head  <= head + brat_ptr_t'(rel_cnt);
            count <= count + brat_cnt_t'(alloc_fire) - rel_cnt;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ent_rob_id[tail]  <= alloc_rob_id_i;
            ent_pc[tail]      <= alloc_pc_i;
            ent_ras_tos[tail] <= alloc_ras_tos_i;
        end
        for (int e = 0; e < BRAT_DEPTH; e++) begin
            if (res_hit[e]) begin
                ent_misp[e]       <= res_misp[e];
                ent_jalr[e]       <= res_jalr[e];
                ent_correct_pc[e] <= res_pc[e];
            end
        end
    end

    // ====================
    // Assertions
    // ====================
    a_lane_unique: assert property (@(posedge clk) disable iff (rst_i) !lane_dup)
        else $error("two execute lanes resolve the same ROB id");

    a_alloc_when_ready: assert property (@(posedge clk) disable iff (rst_i)
        alloc_valid_i |-> alloc_ready_o)
        else $error("allocation offered while the table is full");

    // Count tracks the live entries and stays within the depth
    a_count_bound: assert property (@(posedge clk) disable iff (rst_i)
        (count <= brat_cnt_t'(BRAT_DEPTH)) &&
        (count == brat_cnt_t'($countones(ent_valid))))
        else $error("occupancy count out of range or out of step with the live entries");

endmodule

`default_nettype wire

// File: hw/brat_recovery.sv
`timescale 1ns/1ps
`default_nettype none

module brat_recovery (
    input  wire logic          clk,
    input  wire logic          rst_i,

    brat_release_if.recovery   rel,

    output logic               flush_o,
    output brat_pkg::pc_t      redirect_pc_o,
    output logic               redirect_is_jalr_o,
    output logic               ras_restore_o,
    output brat_pkg::ras_tos_t ras_restore_tos_o
);
    import brat_pkg::*;

    logic     misp_hit;
    pc_t      misp_pc;
    logic     misp_jalr;
    ras_tos_t misp_tos;

    logic     flush_q;
    pc_t      redirect_pc_q;
    logic     redirect_jalr_q;
    ras_tos_t restore_tos_q;

    // ====================
    // Mispredicted slot
    // ====================
    // The window ends at a mispredicted branch, so at most one slot hits
    always_comb begin
        misp_hit  = 1'b0;
        misp_pc   = '0;
        misp_jalr = 1'b0;
        misp_tos  = '0;
        for (int k = 0; k < RELEASE_WIDTH; k++) begin
            if (rel.valid[k] && rel.mispredicted[k]) begin
                misp_hit  = 1'b1;
                misp_pc   = rel.correct_pc[k];
                misp_jalr = rel.is_jalr[k];
                misp_tos  = rel.ras_tos[k];
            end
        end
    end

    // One-cycle flush pulse
    always_ff @(posedge clk) begin
        if (rst_i) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= misp_hit;
        end
    end

    // Redirect target and RAS checkpoint
    always_ff @(posedge clk) begin
        if (misp_hit) begin
            redirect_pc_q   <= misp_pc;
            redirect_jalr_q <= misp_jalr;
            restore_tos_q   <= misp_tos;
        end
    end

    assign flush_o            = flush_q;
    assign ras_restore_o      = flush_q;
    assign redirect_pc_o      = redirect_pc_q;
    assign redirect_is_jalr_o = redirect_jalr_q;
    assign ras_restore_tos_o  = restore_tos_q;

    // Table is empty after a squash, so nothing can release next cycle
    a_flush_single: assert property (@(posedge clk) disable iff (rst_i)
        flush_o |=> !flush_o)
        else $error("eager flush held for two cycles");

endmodule

`default_nettype wire

// File: hw/brat_top.sv
`timescale 1ns/1ps
`default_nettype none

module brat_top (
    input  wire logic               clk,
    input  wire logic               rst_i,

    // ====================
    // Allocation from issue
    // ====================
    input  wire logic               alloc_valid_i,
    input  brat_pkg::rob_id_t       alloc_rob_id_i,
    input  brat_pkg::pc_t           alloc_pc_i,
    input  brat_pkg::ras_tos_t      alloc_ras_tos_i,
    output logic                    alloc_ready_o,

    // ====================
    // Execute lanes
    // ====================
    input  wire logic               exec_valid_i        [brat_pkg::EXEC_LANES],
    input  brat_pkg::rob_id_t       exec_rob_id_i       [brat_pkg::EXEC_LANES],
    input  wire logic               exec_mispredicted_i [brat_pkg::EXEC_LANES],
    input  brat_pkg::pc_t           exec_correct_pc_i   [brat_pkg::EXEC_LANES],
    input  wire logic               exec_is_jalr_i      [brat_pkg::EXEC_LANES],

    // ====================
    // In-order release
    // ====================
    output brat_pkg::slot_mask_t    release_valid_o,
    output brat_pkg::rob_id_t       release_rob_id_o [brat_pkg::RELEASE_WIDTH],
    output brat_pkg::slot_mask_t    release_mispredicted_o,

    // ====================
    // Recovery to fetch
    // ====================
    output logic                    flush_o,
    output brat_pkg::pc_t           redirect_pc_o,
    output logic                    redirect_is_jalr_o,
    output logic                    ras_restore_o,
    output brat_pkg::ras_tos_t      ras_restore_tos_o
);
    import brat_pkg::*;

    brat_exec_if    exec_if [EXEC_LANES] ();
    brat_release_if rel_if ();

    for (genvar l = 0; l < EXEC_LANES; l++) begin : g_exec
        assign exec_if[l].valid        = exec_valid_i[l];
        assign exec_if[l].rob_id       = exec_rob_id_i[l];
        assign exec_if[l].mispredicted = exec_mispredicted_i[l];
        assign exec_if[l].correct_pc   = exec_correct_pc_i[l];
        assign exec_if[l].is_jalr      = exec_is_jalr_i[l];
    end

    brat_table brat_table_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .alloc_valid_i   (alloc_valid_i),
        .alloc_rob_id_i  (alloc_rob_id_i),
        .alloc_pc_i      (alloc_pc_i),
        .alloc_ras_tos_i (alloc_ras_tos_i),
        .alloc_ready_o   (alloc_ready_o),
        .exec            (exec_if),
        .rel             (rel_if)
    );

    brat_recovery brat_recovery_i (
        .clk                (clk),
        .rst_i              (rst_i),
        .rel                (rel_if),
        .flush_o            (flush_o),
        .redirect_pc_o      (redirect_pc_o),
        .redirect_is_jalr_o (redirect_is_jalr_o),
        .ras_restore_o      (ras_restore_o),
        .ras_restore_tos_o  (ras_restore_tos_o)
    );

    // Release window straight to the ports
    assign release_valid_o        = rel_if.valid;
    assign release_rob_id_o       = rel_if.rob_id;
    assign release_mispredicted_o = rel_if.mispredicted;

endmodule

`default_nettype wire

// File: dv/brat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module brat_tb;
    import brat_pkg::*;

    localparam int N_BRANCHES     = 600;
    localparam int TIMEOUT_CYCLES = 20 * N_BRANCHES;

    logic       clk;
    logic       rst_i;
    logic       alloc_valid_i;
    rob_id_t    alloc_rob_id_i;
    pc_t        alloc_pc_i;
    ras_tos_t   alloc_ras_tos_i;
    logic       alloc_ready_o;
    logic       exec_valid_i        [EXEC_LANES];
    rob_id_t    exec_rob_id_i       [EXEC_LANES];
    logic       exec_mispredicted_i [EXEC_LANES];
    pc_t        exec_correct_pc_i   [EXEC_LANES];
    logic       exec_is_jalr_i      [EXEC_LANES];
    slot_mask_t release_valid_o;
    rob_id_t    release_rob_id_o    [RELEASE_WIDTH];
    slot_mask_t release_mispredicted_o;
    logic       flush_o;
    pc_t        redirect_pc_o;
    logic       redirect_is_jalr_o;
    logic       ras_restore_o;
    ras_tos_t   ras_restore_tos_o;

    // ====================
    // Reference model state
    // ====================
    // Live branches in program order with the oldest at index 0
    rob_id_t  m_id   [BRAT_DEPTH];
    ras_tos_t m_tos  [BRAT_DEPTH];
    bit       m_res  [BRAT_DEPTH];
    bit       m_misp [BRAT_DEPTH];
    bit       m_jalr [BRAT_DEPTH];
    pc_t      m_cpc  [BRAT_DEPTH];
    int       m_n;

    // Recovery expected in the cycle after a mispredicted release
    bit       exp_flush;
    pc_t      exp_pc;
    bit       exp_jalr;
    ras_tos_t exp_tos;

    integer  seed;
    rob_id_t next_id;
    int      n_alloc;
    int      cycle_count = 0;
    int      n_flush;
    int      n_full;
    int      n_triple;

    brat_top brat_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Checks
    // ====================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_release(input string name, input slot_mask_t exp_v,
                                 input slot_mask_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp_v, act_v));
    endtask

    task automatic check_rob_id(input string name, input rob_id_t exp_v, input rob_id_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Fail at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v));
    endtask

    task automatic check_redirect(input string name, input pc_t exp_v, input pc_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v));
    endtask

    task automatic check_ras(input string name, input ras_tos_t exp_v, input ras_tos_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Fail at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v));
    endtask

    task automatic check_flag(input string name, input bit exp_v, input logic act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp_v, act_v));
    endtask

    // ====================
    // Reference function
    // ====================
    // Slot k shows the k+1 oldest branches when all are resolved
    // and none of the older ones in the window mispredicted
    function automatic slot_mask_t ref_window(output slot_mask_t misp_mask, output int cnt);
        slot_mask_t mask;
        bit         ok;
        mask      = '0;
        misp_mask = '0;
        cnt       = 0;
        for (int k = 0; k < RELEASE_WIDTH; k++) begin
            ok = (k < m_n);
            for (int j = 0; j <= k; j++) begin
                if (j >= m_n || !m_res[j])
                    ok = 1'b0;
                else if (j < k && m_misp[j])
                    ok = 1'b0;
            end
            if (ok) begin
                mask[k]      = 1'b1;
                misp_mask[k] = m_misp[k];
                cnt++;
            end
        end
        return mask;
    endfunction

    // Model update for one rising edge from the inputs held over the cycle
    task automatic advance_model();
        slot_mask_t mask;
        slot_mask_t mmask;
        int         cnt;
        bit         fire;
        fire      = alloc_valid_i && (m_n < BRAT_DEPTH);
        mask      = ref_window(mmask, cnt);
        exp_flush = 1'b0;
        if (mmask != '0) begin
            // The allocation at this edge is wrong-path too
            for (int k = 0; k < RELEASE_WIDTH; k++) begin
                if (mmask[k]) begin
                    exp_pc   = m_cpc[k];
                    exp_jalr = m_jalr[k];
                    exp_tos  = m_tos[k];
                end
            end
            exp_flush = 1'b1;
            m_n       = 0;
            n_flush++;
        end else begin
            for (int l = 0; l < EXEC_LANES; l++) begin
                for (int e = 0; e < m_n; e++) begin
                    if (exec_valid_i[l] && !m_res[e] && m_id[e] == exec_rob_id_i[l]) begin
                        m_res[e]  = 1'b1;
                        m_misp[e] = exec_mispredicted_i[l];
                        m_jalr[e] = exec_is_jalr_i[l];
                        m_cpc[e]  = exec_correct_pc_i[l];
                    end
                end
            end
            for (int e = 0; e + cnt < m_n; e++) begin
                m_id[e]   = m_id[e + cnt];
                m_tos[e]  = m_tos[e + cnt];
                m_res[e]  = m_res[e + cnt];
                m_misp[e] = m_misp[e + cnt];
                m_jalr[e] = m_jalr[e + cnt];
                m_cpc[e]  = m_cpc[e + cnt];
            end
            m_n = m_n - cnt;
            if (fire) begin
                m_id[m_n]  = alloc_rob_id_i;
                m_tos[m_n] = alloc_ras_tos_i;
                m_res[m_n] = 1'b0;
                m_n++;
            end
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic drive_inputs();
        int cand [BRAT_DEPTH];
        int nc;
        int pick;
        int rate;
        // Every fourth window of 32 cycles resolves nothing so the table fills
        rate = (n_alloc < N_BRANCHES && (cycle_count / 32) % 4 == 3) ? 0 : 5;
        alloc_valid_i = 1'b0;
        if (n_alloc < N_BRANCHES && m_n < BRAT_DEPTH && ($random(seed) & 3) != 0) begin
            alloc_valid_i   = 1'b1;
            alloc_rob_id_i  = next_id;
            alloc_pc_i      = $random(seed);
            alloc_ras_tos_i = ras_tos_t'($random(seed));
            next_id++;
            n_alloc++;
        end
        nc = 0;
        for (int e = 0; e < m_n; e++) begin
            if (!m_res[e]) begin
                cand[nc] = e;
                nc++;
            end
        end
        for (int l = 0; l < EXEC_LANES; l++) begin
            exec_valid_i[l] = 1'b0;
            if (nc > 0 && ($random(seed) & 7) < rate) begin
                // Half the picks take the youngest, which drives reverse order
                pick = ($random(seed) & 1) ? nc - 1 : {$random(seed)} % nc;
                exec_valid_i[l]        = 1'b1;
                exec_rob_id_i[l]       = m_id[cand[pick]];
                exec_mispredicted_i[l] = ($random(seed) & 7) == 0;
                exec_correct_pc_i[l]   = $random(seed);
                exec_is_jalr_i[l]      = $random(seed);
                cand[pick]             = cand[nc - 1];
                nc--;
            end
        end
    endtask

    task automatic check_outputs();
        slot_mask_t mask;
        slot_mask_t mmask;
        int         cnt;
        mask = ref_window(mmask, cnt);
        check_flag("alloc_ready_o", m_n < BRAT_DEPTH, alloc_ready_o);
        check_release("release_valid_o", mask, release_valid_o);
        check_release("release_mispredicted_o", mmask, release_mispredicted_o);
        for (int k = 0; k < RELEASE_WIDTH; k++) begin
            if (mask[k])
                check_rob_id($sformatf("release_rob_id_o[%0d]", k), m_id[k], release_rob_id_o[k]);
        end
        check_flag("flush_o", exp_flush, flush_o);
        check_flag("ras_restore_o", exp_flush, ras_restore_o);
        if (exp_flush) begin
            check_redirect("redirect_pc_o", exp_pc, redirect_pc_o);
            check_flag("redirect_is_jalr_o", exp_jalr, redirect_is_jalr_o);
            check_ras("ras_restore_tos_o", exp_tos, ras_restore_tos_o);
        end
        if (m_n == BRAT_DEPTH)
            n_full++;
        if (cnt == RELEASE_WIDTH)
            n_triple++;
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run("Timeout: the branches did not all drain within the cycle limit");
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        seed            = 50;
        rst_i           = 1'b1;
        alloc_valid_i   = 1'b0;
        alloc_rob_id_i  = '0;
        alloc_pc_i      = '0;
        alloc_ras_tos_i = '0;
        for (int l = 0; l < EXEC_LANES; l++) begin
            exec_valid_i[l]        = 1'b0;
            exec_rob_id_i[l]       = '0;
            exec_mispredicted_i[l] = 1'b0;
            exec_correct_pc_i[l]   = '0;
            exec_is_jalr_i[l]      = 1'b0;
        end
        m_n       = 0;
        exp_flush = 1'b0;
        next_id   = '0;
        n_alloc   = 0;
        n_flush   = 0;
        n_full    = 0;
        n_triple  = 0;

        repeat (16) @(posedge clk);
        #5;
        rst_i = 1'b0;
        #45;
        check_outputs();

        do begin
            @(posedge clk);
            advance_model();
            #5;
            drive_inputs();
            #45;
            check_outputs();
        end while (!(n_alloc == N_BRANCHES && m_n == 0 && !alloc_valid_i && !exp_flush));

        if (n_flush == 0 || n_full == 0 || n_triple == 0) begin
            fail_run("The stimulus never reached a flush, a full table and a three-wide release");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/brat_pkg.sv
hw/brat_exec_if.sv
hw/brat_release_if.sv
hw/brat_table.sv
hw/brat_recovery.sv
hw/brat_top.sv
dv/brat_tb.sv

// File: Bender.yml
package:
  name: brat

sources:
  - files:
      - hw/brat_pkg.sv
      - hw/brat_exec_if.sv
      - hw/brat_release_if.sv
      - hw/brat_table.sv
      - hw/brat_recovery.sv
      - hw/brat_top.sv
  - target: test
    files:
      - dv/brat_tb.sv
